// ==== hw/cube_pkg.sv ====
package cube_pkg;

    //////////////////////////////////////////////////
    // Data widths
    //////////////////////////////////////////////////

    localparam int COLOR_W   = 8;                   // One colour byte per lane
    localparam int DIM_W     = 8;                   // Shared brightness factor
    localparam int PRODUCT_W = COLOR_W + DIM_W;     // Full multiply result
    localparam int BIT_IDX_W = $clog2(COLOR_W);     // Steps and bits per byte

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [COLOR_W-1:0]   color_t;          // Lane colour, in or scaled out
    typedef logic [DIM_W-1:0]     dim_t;            // Dim factor of a word
    typedef logic [PRODUCT_W-1:0] product_t;        // Multiply accumulator
    typedef logic [BIT_IDX_W-1:0] bit_idx_t;        // Multiply step or output bit

    // Frame and word sequencing
    typedef enum logic [2:0] {
        ST_IDLE,                                    // Waiting for enable
        ST_LOAD,                                    // Ready for the next word
        ST_MULT,                                    // Eight shift-and-add steps
        ST_SEND,                                    // Eight pulse-coded bits
        ST_FINISHED                                 // Frame done, waiting for ack
    } seq_state_t;

endpackage

// ==== hw/raster_sequencer.sv ====
`timescale 1ns/1ns

module raster_sequencer
    import cube_pkg::*;
#(
    parameter int NUM_LANES       = 10,
    parameter int WORDS_PER_FRAME = 3,
    parameter int BIT_PERIOD      = 20
) (
    input  logic clk,
    input  logic reset,

    input  logic enable_i,
    input  logic ack_i,
    input  logic pix_valid_i,
    input  dim_t pix_dim_i,
    input  logic period_end_i,

    output logic pix_ready_o,
    output logic finished_o,

    output logic load_o,
    output logic mult_step_o,
    output logic mult_add_o,
    output logic send_o,
    output logic shift_o,
    output logic timer_run_o
);

    localparam int WORD_W = (WORDS_PER_FRAME > 1) ? $clog2(WORDS_PER_FRAME) : 1;
    localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(WORDS_PER_FRAME - 1);
    localparam bit_idx_t LAST_STEP = bit_idx_t'(COLOR_W - 1);

    seq_state_t        state;
    seq_state_t        state_next;
    bit_idx_t          step_cnt;                    // Multiply step, then output bit
    logic [WORD_W-1:0] word_cnt;                    // Words sent in this frame
    dim_t              dim_q;                       // Dim factor, consumed LSB first
    logic              xfer;
    logic              last_step;
    logic              last_word;
    logic              word_done;

    // Catch a bad parameter set while elaborating
    if (NUM_LANES < 1 || WORDS_PER_FRAME < 1 || BIT_PERIOD < 2) begin : g_param_check
        $error("raster_sequencer: NUM_LANES, WORDS_PER_FRAME or BIT_PERIOD out of range");
    end

    assign xfer      = pix_ready_o & pix_valid_i;   // Word accepted on this edge
    assign last_step = (step_cnt == LAST_STEP);
    assign last_word = (word_cnt == LAST_WORD);
    assign word_done = (state == ST_SEND) && period_end_i && last_step;

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (enable_i) begin
                    state_next = ST_LOAD;
                end
            end
            ST_LOAD: begin
                if (xfer) begin
                    state_next = ST_MULT;
                end
            end
            ST_MULT: begin
                if (last_step) begin
                    state_next = ST_SEND;
                end
            end
            ST_SEND: begin
                if (word_done) begin
                    state_next = last_word ? ST_FINISHED : ST_LOAD;
                end
            end
            ST_FINISHED: begin
                if (ack_i) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // State, counters and registered outputs
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            step_cnt    <= '0;
            word_cnt    <= '0;
            pix_ready_o <= 1'b0;
            finished_o  <= 1'b0;
            send_o      <= 1'b0;
            shift_o     <= 1'b0;
        end else begin
            state       <= state_next;
            pix_ready_o <= (state_next == ST_LOAD);
            finished_o  <= (state_next == ST_FINISHED);

            // Lanes see send and shift one cycle late, in step with the
            // registered pulse levels of the bit timer
            send_o      <= (state == ST_SEND);
            shift_o     <= (state == ST_SEND) && period_end_i;

            // Wraps to zero after eight steps or eight bits
            if (state == ST_MULT || ((state == ST_SEND) && period_end_i)) begin
                step_cnt <= step_cnt + 1'b1;
            end

            if (word_done) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
        end
    end

    // Dim register, shifted right once per multiply step
    always_ff @(posedge clk) begin
        if (xfer) begin
            dim_q <= pix_dim_i;
        end else if (state == ST_MULT) begin
            dim_q <= dim_q >> 1;
        end
    end

    assign load_o      = xfer;                      // Lanes capture colour with the word
    assign mult_step_o = (state == ST_MULT);
    assign mult_add_o  = dim_q[0];                  // Current multiplier bit
    assign timer_run_o = (state == ST_SEND);

endmodule

// ==== hw/bit_timer.sv ====
`timescale 1ns/1ns

module bit_timer #(
    parameter int BIT_PERIOD = 20,
    parameter int ONE_HIGH   = 13,
    parameter int ZERO_HIGH  = 6
) (
    input  logic clk,
    input  logic reset,
    input  logic timer_run_i,

    output logic period_end_o,
    output logic one_level_o,
    output logic zero_level_o
);

    localparam int CNT_W = $clog2(BIT_PERIOD);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(BIT_PERIOD - 1);
    localparam logic [CNT_W-1:0] ONE_CNT  = CNT_W'(ONE_HIGH);
    localparam logic [CNT_W-1:0] ZERO_CNT = CNT_W'(ZERO_HIGH);

    logic [CNT_W-1:0] cnt;                          // Position within the bit period

    // Both pulse widths must fit inside one bit period
    if (!(ZERO_HIGH > 0 && ZERO_HIGH < ONE_HIGH && ONE_HIGH < BIT_PERIOD)) begin : g_param_check
        $error("bit_timer: need 0 < ZERO_HIGH < ONE_HIGH < BIT_PERIOD");
    end

    //////////////////////////////////////////////////
    // Period counter and pulse levels
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt          <= '0;
            one_level_o  <= 1'b0;
            zero_level_o <= 1'b0;
        end else begin
            if (!timer_run_i || cnt == LAST_CNT) begin
                cnt <= '0;                          // Held at zero while stopped
            end else begin
                cnt <= cnt + 1'b1;
            end

            // Levels trail the count by one cycle
            one_level_o  <= timer_run_i && (cnt < ONE_CNT);
            zero_level_o <= timer_run_i && (cnt < ZERO_CNT);
        end
    end

    assign period_end_o = timer_run_i && (cnt == LAST_CNT);

endmodule

// ==== hw/lane_shifter.sv ====
`timescale 1ns/1ns

module lane_shifter
    import cube_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  color_t color_i,

    input  logic   load_i,
    input  logic   mult_step_i,
    input  logic   mult_add_i,
    input  logic   send_i,
    input  logic   shift_i,
    input  logic   one_level_i,
    input  logic   zero_level_i,

    output logic   sout_o
);

    product_t acc;                                  // Colour times dim
    product_t mcand;                                // Colour, moved left each step
    color_t   out_q;                                // Byte on its way out, MSB first

    //////////////////////////////////////////////////
    // Shift-and-add multiply
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load_i) begin
            acc   <= '0;
            mcand <= product_t'(color_i);
        end else if (mult_step_i) begin
            if (mult_add_i) begin
                acc <= acc + mcand;
            end
            mcand <= mcand << 1;
        end
    end

    //////////////////////////////////////////////////
    // Serial output
    //////////////////////////////////////////////////

    // Upper byte of the product is the scaled colour
    always_ff @(posedge clk) begin
        if (!send_i) begin
            out_q <= acc[PRODUCT_W-1 -: COLOR_W];   // Follows the product until sending
        end else if (shift_i) begin
            out_q <= {out_q[COLOR_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sout_o <= 1'b0;
        end else if (send_i) begin
            sout_o <= out_q[COLOR_W-1] ? one_level_i : zero_level_i;
        end else begin
            sout_o <= 1'b0;
        end
    end

endmodule

// ==== hw/cube_raster.sv ====
`timescale 1ns/1ns

module cube_raster
    import cube_pkg::*;
#(
    parameter int NUM_LANES       = 10,
    parameter int WORDS_PER_FRAME = 3,
    parameter int BIT_PERIOD      = 20,
    parameter int ONE_HIGH        = 13,
    parameter int ZERO_HIGH       = 6
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   enable_i,
    input  logic                   ack_i,

    input  logic                   pix_valid_i,
    output logic                   pix_ready_o,
    input  color_t [NUM_LANES-1:0] pix_color_i,    // One colour byte per lane
    input  dim_t                   pix_dim_i,

    output logic                   finished_o,
    output logic [NUM_LANES-1:0]   sout_o
);

    logic load;
    logic mult_step;
    logic mult_add;
    logic send;
    logic shift;
    logic timer_run;
    logic period_end;
    logic one_level;
    logic zero_level;

    raster_sequencer #(
        .NUM_LANES       (NUM_LANES),
        .WORDS_PER_FRAME (WORDS_PER_FRAME),
        .BIT_PERIOD      (BIT_PERIOD)
    ) i_raster_sequencer (
        .clk          (clk),
        .reset        (reset),
        .enable_i     (enable_i),
        .ack_i        (ack_i),
        .pix_valid_i  (pix_valid_i),
        .pix_dim_i    (pix_dim_i),
        .period_end_i (period_end),
        .pix_ready_o  (pix_ready_o),
        .finished_o   (finished_o),
        .load_o       (load),
        .mult_step_o  (mult_step),
        .mult_add_o   (mult_add),
        .send_o       (send),
        .shift_o      (shift),
        .timer_run_o  (timer_run)
    );

    bit_timer #(
        .BIT_PERIOD (BIT_PERIOD),
        .ONE_HIGH   (ONE_HIGH),
        .ZERO_HIGH  (ZERO_HIGH)
    ) i_bit_timer (
        .clk          (clk),
        .reset        (reset),
        .timer_run_i  (timer_run),
        .period_end_o (period_end),
        .one_level_o  (one_level),
        .zero_level_o (zero_level)
    );

    // Every lane sees the same control and pulse levels
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_shifter i_lane_shifter (
            .clk          (clk),
            .reset        (reset),
            .color_i      (pix_color_i[i]),
            .load_i       (load),
            .mult_step_i  (mult_step),
            .mult_add_i   (mult_add),
            .send_i       (send),
            .shift_i      (shift),
            .one_level_i  (one_level),
            .zero_level_i (zero_level),
            .sout_o       (sout_o[i])
        );
    end

endmodule

// ==== dv/lane_decoder.sv ====
`timescale 1ns/1ns

module lane_decoder
    import cube_pkg::*;
#(
    parameter int ONE_HIGH = 13
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   sout_i,

    output logic   byte_valid_o,
    output color_t byte_o,
    output int     byte_count_o,
    output logic   pulse_end_o,
    output int     pulse_len_o,
    output logic   gap_valid_o,
    output int     gap_o
);

    logic     sout_q;
    int       high_cnt;                             // High samples of the current pulse
    int       since_start;                          // Cycles since the last pulse start
    bit_idx_t bit_cnt;                              // Bit position within the byte
    color_t   bits_q;
    logic     bit_val;

    assign bit_val = (high_cnt == ONE_HIGH);        // Any other width decodes as 0

    always_ff @(posedge clk) begin
        if (reset) begin
            sout_q       <= 1'b0;
            high_cnt     <= 0;
            since_start  <= 0;
            bit_cnt      <= '0;
            bits_q       <= '0;
            byte_valid_o <= 1'b0;
            byte_o       <= '0;
            byte_count_o <= 0;
            pulse_end_o  <= 1'b0;
            pulse_len_o  <= 0;
            gap_valid_o  <= 1'b0;
            gap_o        <= 0;
        end else begin
            sout_q       <= sout_i;
            byte_valid_o <= 1'b0;
            pulse_end_o  <= 1'b0;
            gap_valid_o  <= 1'b0;
            since_start  <= since_start + 1;

            if (sout_i && !sout_q) begin
                high_cnt    <= 1;
                since_start <= 1;
                gap_valid_o <= (bit_cnt != '0);     // First bit of a word has no spacing
                gap_o       <= since_start;
            end else if (sout_i) begin
                high_cnt <= high_cnt + 1;
            end

            // Falling edge closes one bit
            if (!sout_i && sout_q) begin
                pulse_end_o <= 1'b1;
                pulse_len_o <= high_cnt;
                bits_q      <= {bits_q[COLOR_W-2:0], bit_val};
                bit_cnt     <= bit_cnt + 1'b1;
                if (bit_cnt == bit_idx_t'(COLOR_W - 1)) begin
                    byte_valid_o <= 1'b1;
                    byte_o       <= {bits_q[COLOR_W-2:0], bit_val};
                    byte_count_o <= byte_count_o + 1;
                end
            end
        end
    end

endmodule

// ==== dv/cube_raster_tb.sv ====
`timescale 1ns/1ns

module cube_raster_tb
    import cube_pkg::*;
();

    localparam int NUM_LANES       = 10;
    localparam int WORDS_PER_FRAME = 3;
    localparam int BIT_PERIOD      = 20;
    localparam int ONE_HIGH        = 13;
    localparam int ZERO_HIGH       = 6;
    localparam int NUM_FRAMES      = 9;
    localparam int WATCHDOG_CYCLES =
        NUM_FRAMES * WORDS_PER_FRAME * (8 * BIT_PERIOD + 20) * 2;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   enable_i;
    logic                   ack_i;
    logic                   pix_valid_i;
    logic                   pix_ready_o;
    color_t [NUM_LANES-1:0] pix_color_i;
    dim_t                   pix_dim_i;
    logic                   finished_o;
    logic [NUM_LANES-1:0]   sout_o;

    logic                   xfer;
    logic                   seen_reset = 1'b0;
    logic                   seen_enable = 1'b0;
    int                     words_total;            // Words accepted since reset
    int                     frame_words;            // Words accepted in this frame
    color_t                 exp_byte [NUM_LANES];
    int                     fail_cnt = 0;
    int                     fails_at_start;
    int                     tests_run = 0;
    int                     tests_failed = 0;
    string                  test_name = "none";

    logic [NUM_LANES-1:0]   byte_valid;
    logic [NUM_LANES-1:0]   pulse_end;
    logic [NUM_LANES-1:0]   gap_valid;
    color_t                 byte_val [NUM_LANES];
    int                     byte_count [NUM_LANES];
    int                     pulse_len [NUM_LANES];
    int                     gap [NUM_LANES];

    always #4 clk = ~clk;

    cube_raster i_cube_raster (
        .clk         (clk),
        .reset       (reset),
        .enable_i    (enable_i),
        .ack_i       (ack_i),
        .pix_valid_i (pix_valid_i),
        .pix_ready_o (pix_ready_o),
        .pix_color_i (pix_color_i),
        .pix_dim_i   (pix_dim_i),
        .finished_o  (finished_o),
        .sout_o      (sout_o)
    );

    assign xfer = pix_valid_i && pix_ready_o;

    // Expected bytes follow floor(colour * dim / 256)
    always @(posedge clk) begin
        if (reset) begin
            seen_reset  <= 1'b1;
            words_total <= 0;
            frame_words <= 0;
        end else begin
            if (enable_i) begin
                seen_enable <= 1'b1;
            end
            if (xfer) begin
                words_total <= words_total + 1;
                frame_words <= frame_words + 1;
                for (int i = 0; i < NUM_LANES; i++) begin
                    exp_byte[i] <= color_t'((product_t'(pix_color_i[i])
                                             * product_t'(pix_dim_i)) >> COLOR_W);
                end
            end
            if (finished_o && ack_i) begin
                frame_words <= 0;                   // Ack closes the frame
            end
        end
    end

    //////////////////////////////////////////////////
    // Engine level checks
    //////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk)
        seen_reset && !seen_enable |-> !pix_ready_o && !finished_o && sout_o == '0)
    else begin
        $display("error %s: outputs active before the first enable", test_name);
        fail_cnt++;
    end

    a_ready_held: assert property (@(posedge clk) disable iff (reset)
        pix_ready_o && !pix_valid_i |=> pix_ready_o)
    else begin
        $display("error %s: ready dropped while no word was offered", test_name);
        fail_cnt++;
    end

    a_load_quiet: assert property (@(posedge clk) disable iff (reset)
        pix_ready_o |-> sout_o == '0)
    else begin
        $display("error %s: serial output active while waiting for a word", test_name);
        fail_cnt++;
    end

    a_finished_held: assert property (@(posedge clk) disable iff (reset)
        finished_o && !ack_i |=> finished_o && !pix_ready_o)
    else begin
        $display("error %s: finished flag lost or ready raised before ack", test_name);
        fail_cnt++;
    end

    a_finished_clear: assert property (@(posedge clk) disable iff (reset)
        finished_o && ack_i |=> !finished_o)
    else begin
        $display("error %s: finished flag still high after ack", test_name);
        fail_cnt++;
    end

    a_frame_len: assert property (@(posedge clk) disable iff (reset)
        $rose(finished_o) |-> frame_words == WORDS_PER_FRAME)
    else begin
        $display("error %s frame length: expected %0d, actual %0d",
                 test_name, WORDS_PER_FRAME, $sampled(frame_words));
        fail_cnt++;
    end

    a_no_extra: assert property (@(posedge clk) disable iff (reset)
        xfer |-> frame_words < WORDS_PER_FRAME)
    else begin
        $display("error %s: word accepted beyond the end of the frame", test_name);
        fail_cnt++;
    end

    //////////////////////////////////////////////////
    // Per lane decoding and checks
    //////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_decoder #(
            .ONE_HIGH (ONE_HIGH)
        ) i_lane_decoder (
            .clk          (clk),
            .reset        (reset),
            .sout_i       (sout_o[i]),
            .byte_valid_o (byte_valid[i]),
            .byte_o       (byte_val[i]),
            .byte_count_o (byte_count[i]),
            .pulse_end_o  (pulse_end[i]),
            .pulse_len_o  (pulse_len[i]),
            .gap_valid_o  (gap_valid[i]),
            .gap_o        (gap[i])
        );

        a_byte: assert property (@(posedge clk) disable iff (reset)
            byte_valid[i] |-> byte_val[i] == exp_byte[i])
        else begin
            $display("error %s lane %0d: expected %02h, actual %02h",
                     test_name, i, $sampled(exp_byte[i]), $sampled(byte_val[i]));
            fail_cnt++;
        end

        a_width: assert property (@(posedge clk) disable iff (reset)
            pulse_end[i] |-> pulse_len[i] == ONE_HIGH || pulse_len[i] == ZERO_HIGH)
        else begin
            $display("error %s lane %0d pulse width: expected %0d or %0d, actual %0d",
                     test_name, i, ONE_HIGH, ZERO_HIGH, $sampled(pulse_len[i]));
            fail_cnt++;
        end

        a_spacing: assert property (@(posedge clk) disable iff (reset)
            gap_valid[i] |-> gap[i] == BIT_PERIOD)
        else begin
            $display("error %s lane %0d pulse spacing: expected %0d, actual %0d",
                     test_name, i, BIT_PERIOD, $sampled(gap[i]));
            fail_cnt++;
        end

        // Every accepted word gives exactly one byte per lane
        a_count: assert property (@(posedge clk) disable iff (reset)
            xfer || $rose(finished_o) |-> byte_count[i] == words_total)
        else begin
            $display("error %s lane %0d byte count: expected %0d, actual %0d",
                     test_name, i, $sampled(words_total), $sampled(byte_count[i]));
            fail_cnt++;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic start_test(input string name);
        test_name      = name;
        fails_at_start = fail_cnt;
    endtask

    task automatic report_test();
        tests_run++;
        if (fail_cnt == fails_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, fail_cnt - fails_at_start);
        end
    endtask

    task automatic send_word(input dim_t dim, input int gap_cycles);
        if (gap_cycles > 0) begin
            while (!pix_ready_o) @(posedge clk);    // Hold valid off while ready
            repeat (gap_cycles) @(posedge clk);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            pix_color_i[i] <= color_t'($urandom);
        end
        pix_dim_i   <= dim;
        pix_valid_i <= 1'b1;
        @(posedge clk);
        while (!pix_ready_o) @(posedge clk);
        pix_valid_i <= 1'b0;
    endtask

    // A negative dim picks a random one per word
    task automatic run_frame(input int dim, input int max_gap, input int ack_wait);
        int gap_cycles;
        @(posedge clk);
        enable_i <= 1'b1;
        @(posedge clk);
        enable_i <= 1'b0;
        for (int w = 0; w < WORDS_PER_FRAME; w++) begin
            gap_cycles = (max_gap > 0) ? int'($urandom_range(max_gap, 1)) : 0;
            send_word((dim < 0) ? dim_t'($urandom) : dim_t'(dim), gap_cycles);
        end
        pix_valid_i <= 1'b1;                        // Spare word the engine must refuse
        while (!finished_o) @(posedge clk);
        repeat (ack_wait) @(posedge clk);
        ack_i       <= 1'b1;
        pix_valid_i <= 1'b0;
        @(posedge clk);
        ack_i <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'ha2f7af4f));
        reset       <= 1'b1;
        enable_i    <= 1'b0;
        ack_i       <= 1'b0;
        pix_valid_i <= 1'b0;
        pix_color_i <= '0;
        pix_dim_i   <= '0;

        start_test("reset_state");
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (10) @(posedge clk);
        report_test();

        start_test("full_scale");
        run_frame(255, 0, 0);
        report_test();

        start_test("scaling");
        run_frame(0, 0, 0);                         // Zero dim first
        repeat (3) run_frame(-1, 0, 0);
        report_test();

        start_test("pulse_shape");
        run_frame(-1, 0, 0);
        report_test();

        start_test("back_pressure");
        run_frame(-1, 8, 0);
        report_test();

        start_test("frame_end");
        run_frame(-1, 0, 1 + int'($urandom_range(20)));
        run_frame(-1, 2, 3);
        report_test();

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles in test %s",
                 WATCHDOG_CYCLES, test_name);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
hw/cube_pkg.sv
hw/raster_sequencer.sv
hw/bit_timer.sv
hw/lane_shifter.sv
hw/cube_raster.sv
dv/lane_decoder.sv
dv/cube_raster_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the LED cube raster engine

TOP = cube_raster_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall \
		hw/cube_pkg.sv hw/raster_sequencer.sv hw/bit_timer.sv \
		hw/lane_shifter.sv hw/cube_raster.sv --top-module cube_raster

clean:
	rm -rf obj_dir sim.log
